// File: verilog/csr_cfg.svh
////////////////////////////////////////////////////////////////////////////
// widths shared by the CSR file RTL and its testbench
// pc and load/store addresses must not be wider than CSR_WIDTH, they are
// zero-extended into the 64-bit registers
// CSR_COUNT must match the index constants of the address map package
////////////////////////////////////////////////////////////////////////////

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// register and address widths
`define CSR_WIDTH        64
`define CSR_ADDR_WIDTH   12
`define CSR_COUNT        8

// core side widths
`define PC_WIDTH         32
`define VADDR_WIDTH      32

// commit total is up to 4 instructions per cycle, 3 bits
`define COMMIT_CNT_WIDTH 3
`define CAUSE_WIDTH      5

`endif

// File: verilog/csr_map_pkg.sv
////////////////////////////////////////////////////////////////////////////
// supervisor CSR address map and register bank slots
// only the eight kept registers are mapped, every other address reads
// as zero and ignores writes
////////////////////////////////////////////////////////////////////////////

`include "csr_cfg.svh"

package csr_map_pkg;

  // 12-bit CSR addresses
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_SUP0     = 12'h500;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_SUP1     = 12'h501;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_EPC      = 12'h502;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_BADVADDR = 12'h503;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_COUNT    = 12'h506;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_EVEC     = 12'h508;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_CAUSE    = 12'h509;
  localparam logic [`CSR_ADDR_WIDTH-1:0] ADDR_STATUS   = 12'h50a;

  // slot in the bank, also the bit in the write strobe and read select
  localparam int unsigned IDX_SUP0     = 0;
  localparam int unsigned IDX_SUP1     = 1;
  localparam int unsigned IDX_EPC      = 2;
  localparam int unsigned IDX_BADVADDR = 3;
  localparam int unsigned IDX_COUNT    = 4;
  localparam int unsigned IDX_EVEC     = 5;
  localparam int unsigned IDX_CAUSE    = 6;
  localparam int unsigned IDX_STATUS   = 7;

endpackage

// File: verilog/csr_trap_pkg.sv
////////////////////////////////////////////////////////////////////////////
// exception causes and the supervisor status word
// IM/IP interrupt fields are not kept, status bits above VM read as zero
// EA is not writable and always reads zero
////////////////////////////////////////////////////////////////////////////

`include "csr_cfg.svh"

package csr_trap_pkg;

  // causes that load badvaddr, all others leave it alone
  localparam logic [`CAUSE_WIDTH-1:0] CAUSE_MISALIGNED_FETCH = 5'd0;
  localparam logic [`CAUSE_WIDTH-1:0] CAUSE_FAULT_FETCH      = 5'd1;
  localparam logic [`CAUSE_WIDTH-1:0] CAUSE_MISALIGNED_LOAD  = 5'd4;
  localparam logic [`CAUSE_WIDTH-1:0] CAUSE_FAULT_LOAD       = 5'd5;
  localparam logic [`CAUSE_WIDTH-1:0] CAUSE_MISALIGNED_STORE = 5'd6;
  localparam logic [`CAUSE_WIDTH-1:0] CAUSE_FAULT_STORE      = 5'd7;

  // status bit positions
  localparam int unsigned SR_S_BIT   = 0;
  localparam int unsigned SR_PS_BIT  = 1;
  localparam int unsigned SR_EI_BIT  = 2;
  localparam int unsigned SR_PEI_BIT = 3;
  localparam int unsigned SR_EF_BIT  = 4;
  localparam int unsigned SR_U64_BIT = 5;
  localparam int unsigned SR_S64_BIT = 6;
  localparam int unsigned SR_VM_BIT  = 7;
  localparam int unsigned SR_EA_BIT  = 8;

  // everything below EA is writable, 0xff
  localparam logic [`CSR_WIDTH-1:0] STATUS_WRITE_MASK = (64'd1 << SR_EA_BIT) - 64'd1;
  // supervisor mode, 64-bit user and supervisor, 0x61
  localparam logic [`CSR_WIDTH-1:0] STATUS_RESET =
    (64'd1 << SR_S_BIT) | (64'd1 << SR_U64_BIT) | (64'd1 << SR_S64_BIT);

  typedef struct packed {
    logic [`CSR_WIDTH-10:0] rsvd;
    logic                   ea;
    logic                   vm;
    logic                   s64;
    logic                   u64;
    logic                   ef;
    logic                   pei;
    logic                   ei;
    logic                   ps;
    logic                   s;
  } status_fields_t;

  // raw word for csr access, fields for sret
  typedef union packed {
    logic [`CSR_WIDTH-1:0] raw;
    status_fields_t        fields;
  } csr_status_u;

endpackage

// File: verilog/csr_commit_decode.sv
////////////////////////////////////////////////////////////////////////////
// pending CSR write buffer and address decode
// a write is parked on wr_en_i and applied only on commit_i, a commit
// without a fresh wr_en_i replays the last parked write
// unmapped addresses give all-zero strobes and read selects
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_cfg.svh"

module csr_commit_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`CSR_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [`CSR_WIDTH-1:0]      wr_data_i,
  input  logic                       wr_en_i,
  input  logic                       commit_i,
  input  logic [`CSR_ADDR_WIDTH-1:0] rd_addr_i,
  output logic [`CSR_COUNT-1:0]      wr_strobe_o,
  output logic [`CSR_WIDTH-1:0]      wr_data_o,
  output logic [`CSR_COUNT-1:0]      rd_sel_o
);

  logic [`CSR_ADDR_WIDTH-1:0] pend_addr_q;
  logic [`CSR_WIDTH-1:0]      pend_data_q;

  // address to one-hot bank slot, zero when unmapped
  function automatic logic [`CSR_COUNT-1:0] addr_decode(
    input logic [`CSR_ADDR_WIDTH-1:0] addr
  );
    logic [`CSR_COUNT-1:0] sel;
    sel = '0;
    case (addr)
      csr_map_pkg::ADDR_SUP0:     sel[csr_map_pkg::IDX_SUP0]     = 1'b1;
      csr_map_pkg::ADDR_SUP1:     sel[csr_map_pkg::IDX_SUP1]     = 1'b1;
      csr_map_pkg::ADDR_EPC:      sel[csr_map_pkg::IDX_EPC]      = 1'b1;
      csr_map_pkg::ADDR_BADVADDR: sel[csr_map_pkg::IDX_BADVADDR] = 1'b1;
      csr_map_pkg::ADDR_COUNT:    sel[csr_map_pkg::IDX_COUNT]    = 1'b1;
      csr_map_pkg::ADDR_EVEC:     sel[csr_map_pkg::IDX_EVEC]     = 1'b1;
      csr_map_pkg::ADDR_CAUSE:    sel[csr_map_pkg::IDX_CAUSE]    = 1'b1;
      csr_map_pkg::ADDR_STATUS:   sel[csr_map_pkg::IDX_STATUS]   = 1'b1;
      default:                    sel = '0;
    endcase
    return sel;
  endfunction

  // pending address starts unmapped so an early commit writes nothing
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pend_addr_q <= '0;
    end
    else if (wr_en_i)
    begin
      pend_addr_q <= wr_addr_i;
    end
  end

  // pending data is payload only
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      pend_data_q <= wr_data_i;
    end
  end

  // strobe lives for the commit cycle only
  assign wr_strobe_o = commit_i ? addr_decode(pend_addr_q) : '0;
  assign wr_data_o   = pend_data_q;
  // read select is purely combinational, zero latency reads
  assign rd_sel_o    = addr_decode(rd_addr_i);

endmodule

// File: verilog/csr_state_regs.sv
////////////////////////////////////////////////////////////////////////////
// the eight supervisor CSRs
// a committed write wins over exception, count and sret updates
// count advances every cycle by the commit total plus one per exception
// pc and addresses are zero-extended, status writes keep bits 7:0 only
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_cfg.svh"

module csr_state_regs (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`CSR_COUNT-1:0]                 wr_strobe_i,
  input  logic [`CSR_WIDTH-1:0]                 wr_data_i,
  input  logic [`COMMIT_CNT_WIDTH-1:0]          commit_total_i,
  input  logic                                  exception_i,
  input  logic [`PC_WIDTH-1:0]                  exception_pc_i,
  input  logic [`CAUSE_WIDTH-1:0]               exception_cause_i,
  input  logic [`VADDR_WIDTH-1:0]               ld_commit_addr_i,
  input  logic [`VADDR_WIDTH-1:0]               st_commit_addr_i,
  input  logic                                  sret_i,
  output logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] csr_bank_o
);

  localparam int PC_PAD    = `CSR_WIDTH - `PC_WIDTH;
  localparam int VADDR_PAD = `CSR_WIDTH - `VADDR_WIDTH;
  localparam int CAUSE_PAD = `CSR_WIDTH - `CAUSE_WIDTH;
  localparam int CNT_PAD   = `CSR_WIDTH - `COMMIT_CNT_WIDTH - 1;

  logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] bank_q;
  logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] hold_next;
  logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] bank_d;
  logic [`COMMIT_CNT_WIDTH:0]            count_inc;
  csr_trap_pkg::csr_status_u             status_cur;
  csr_trap_pkg::csr_status_u             status_nxt;

  // one extra bit so a full commit plus an exception cannot wrap
  assign count_inc = {1'b0, commit_total_i} + {{`COMMIT_CNT_WIDTH{1'b0}}, exception_i};

  // hardware-side next values, before any committed write
  always_comb
  begin
    hold_next = bank_q;
    hold_next[csr_map_pkg::IDX_COUNT] =
      bank_q[csr_map_pkg::IDX_COUNT] + {{CNT_PAD{1'b0}}, count_inc};
    if (exception_i)
    begin
      hold_next[csr_map_pkg::IDX_EPC]   = {{PC_PAD{1'b0}}, exception_pc_i};
      hold_next[csr_map_pkg::IDX_CAUSE] = {{CAUSE_PAD{1'b0}}, exception_cause_i};
      // badvaddr source follows the cause
      case (exception_cause_i)
        csr_trap_pkg::CAUSE_MISALIGNED_FETCH,
        csr_trap_pkg::CAUSE_FAULT_FETCH:
          hold_next[csr_map_pkg::IDX_BADVADDR] = {{PC_PAD{1'b0}}, exception_pc_i};
        csr_trap_pkg::CAUSE_MISALIGNED_LOAD,
        csr_trap_pkg::CAUSE_FAULT_LOAD:
          hold_next[csr_map_pkg::IDX_BADVADDR] = {{VADDR_PAD{1'b0}}, ld_commit_addr_i};
        csr_trap_pkg::CAUSE_MISALIGNED_STORE,
        csr_trap_pkg::CAUSE_FAULT_STORE:
          hold_next[csr_map_pkg::IDX_BADVADDR] = {{VADDR_PAD{1'b0}}, st_commit_addr_i};
        default:
          hold_next[csr_map_pkg::IDX_BADVADDR] = bank_q[csr_map_pkg::IDX_BADVADDR];
      endcase
    end
    // sret pops the previous mode and interrupt enable
    status_cur.raw = bank_q[csr_map_pkg::IDX_STATUS];
    status_nxt     = status_cur;
    if (sret_i)
    begin
      status_nxt.fields.s  = status_cur.fields.ps;
      status_nxt.fields.ei = status_cur.fields.pei;
    end
    hold_next[csr_map_pkg::IDX_STATUS] = status_nxt.raw;
  end

  // committed write overrides, status goes through the write mask
  always_comb
  begin
    for (int i = 0; i < `CSR_COUNT; i++)
    begin
      if (!wr_strobe_i[i])
        bank_d[i] = hold_next[i];
      else if (i == csr_map_pkg::IDX_STATUS)
        bank_d[i] = wr_data_i & csr_trap_pkg::STATUS_WRITE_MASK;
      else
        bank_d[i] = wr_data_i;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bank_q                          <= '0;
      bank_q[csr_map_pkg::IDX_STATUS] <= csr_trap_pkg::STATUS_RESET;
    end
    else
    begin
      bank_q <= bank_d;
    end
  end

  assign csr_bank_o = bank_q;

endmodule

// File: verilog/csr_read_check.sv
////////////////////////////////////////////////////////////////////////////
// CSR read port and read atomicity check
// reads are combinational, an unmapped address returns zero
// the flag is raised while a checkpointed read no longer matches the
// live register, a new rd_en_i takes priority over flush and commit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_cfg.svh"

module csr_read_check (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  flush_i,
  input  logic                                  commit_i,
  input  logic                                  rd_en_i,
  input  logic [`CSR_COUNT-1:0]                 rd_sel_i,
  input  logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] csr_bank_i,
  output logic [`CSR_WIDTH-1:0]                 rd_data_o,
  output logic                                  atomic_rd_vio_o
);

  logic                  chk_valid_q;
  logic [`CSR_COUNT-1:0] chk_sel_q;
  logic [`CSR_WIDTH-1:0] chk_data_q;
  logic [`CSR_WIDTH-1:0] chk_live;

  // and-or mux over the bank, zero select gives zero
  function automatic logic [`CSR_WIDTH-1:0] slot_mux(
    input logic [`CSR_COUNT-1:0]                 sel,
    input logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] bank
  );
    logic [`CSR_WIDTH-1:0] word;
    word = '0;
    for (int i = 0; i < `CSR_COUNT; i++)
    begin
      word = word | (bank[i] & {`CSR_WIDTH{sel[i]}});
    end
    return word;
  endfunction

  assign rd_data_o = slot_mux(rd_sel_i, csr_bank_i);

  // checkpoint valid, the read itself wins over the clear
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      chk_valid_q <= 1'b0;
    else if (rd_en_i)
      chk_valid_q <= 1'b1;
    else if (flush_i || commit_i)
      chk_valid_q <= 1'b0;
  end

  // select and data are only looked at while valid
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_sel_q  <= rd_sel_i;
      chk_data_q <= rd_data_o;
    end
  end

  assign chk_live        = slot_mux(chk_sel_q, csr_bank_i);
  assign atomic_rd_vio_o = chk_valid_q && (chk_live != chk_data_q);

endmodule

// File: verilog/csr_file_top.sv
////////////////////////////////////////////////////////////////////////////
// supervisor CSR file, top level
// writes take effect one edge after commit_i, reads are same cycle
// plain strobes and levels, no back-pressure anywhere
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_cfg.svh"

module csr_file_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         flush_i,
  input  logic [`CSR_ADDR_WIDTH-1:0]   wr_addr_i,
  input  logic [`CSR_WIDTH-1:0]        wr_data_i,
  input  logic                         wr_en_i,
  input  logic                         commit_i,
  input  logic [`CSR_ADDR_WIDTH-1:0]   rd_addr_i,
  input  logic                         rd_en_i,
  input  logic [`COMMIT_CNT_WIDTH-1:0] commit_total_i,
  input  logic                         exception_i,
  input  logic [`PC_WIDTH-1:0]         exception_pc_i,
  input  logic [`CAUSE_WIDTH-1:0]      exception_cause_i,
  input  logic [`VADDR_WIDTH-1:0]      ld_commit_addr_i,
  input  logic [`VADDR_WIDTH-1:0]      st_commit_addr_i,
  input  logic                         sret_i,
  output logic [`CSR_WIDTH-1:0]        rd_data_o,
  output logic                         atomic_rd_vio_o,
  output logic [`CSR_WIDTH-1:0]        csr_epc_o,
  output logic [`CSR_WIDTH-1:0]        csr_evec_o
);

  logic [`CSR_COUNT-1:0]                 wr_strobe;
  logic [`CSR_WIDTH-1:0]                 wr_data;
  logic [`CSR_COUNT-1:0]                 rd_sel;
  logic [`CSR_COUNT-1:0][`CSR_WIDTH-1:0] csr_bank;

  // decode, holds the write until commit
  csr_commit_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .wr_en_i     (wr_en_i),
    .commit_i    (commit_i),
    .rd_addr_i   (rd_addr_i),
    .wr_strobe_o (wr_strobe),
    .wr_data_o   (wr_data),
    .rd_sel_o    (rd_sel)
  );

  // execute, the register bank
  csr_state_regs u_state (
    .clk               (clk),
    .reset             (reset),
    .wr_strobe_i       (wr_strobe),
    .wr_data_i         (wr_data),
    .commit_total_i    (commit_total_i),
    .exception_i       (exception_i),
    .exception_pc_i    (exception_pc_i),
    .exception_cause_i (exception_cause_i),
    .ld_commit_addr_i  (ld_commit_addr_i),
    .st_commit_addr_i  (st_commit_addr_i),
    .sret_i            (sret_i),
    .csr_bank_o        (csr_bank)
  );

  // result, read data and atomicity flag
  csr_read_check u_read (
    .clk             (clk),
    .reset           (reset),
    .flush_i         (flush_i),
    .commit_i        (commit_i),
    .rd_en_i         (rd_en_i),
    .rd_sel_i        (rd_sel),
    .csr_bank_i      (csr_bank),
    .rd_data_o       (rd_data_o),
    .atomic_rd_vio_o (atomic_rd_vio_o)
  );

  // trap return and vector go straight to the fetch unit
  assign csr_epc_o  = csr_bank[csr_map_pkg::IDX_EPC];
  assign csr_evec_o = csr_bank[csr_map_pkg::IDX_EVEC];

endmodule

// File: tb/csr_file_assertions.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks bound into the CSR file top level
// looks at the internal write strobe to spot an epc write
// all properties are off while reset is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_cfg.svh"

module csr_file_assertions (
  input logic                       clk,
  input logic                       reset,
  input logic                       flush_i,
  input logic                       rd_en_i,
  input logic [`CSR_ADDR_WIDTH-1:0] rd_addr_i,
  input logic [`CSR_WIDTH-1:0]      rd_data_o,
  input logic                       atomic_rd_vio_o,
  input logic                       exception_i,
  input logic [`PC_WIDTH-1:0]       exception_pc_i,
  input logic [`CSR_WIDTH-1:0]      csr_epc_o,
  input logic [`CSR_COUNT-1:0]      wr_strobe
);

  logic rd_mapped;
  // number of property failures so far
  int   fail_count = 0;

  // any of the eight kept addresses
  assign rd_mapped = (rd_addr_i == csr_map_pkg::ADDR_SUP0)     ||
                     (rd_addr_i == csr_map_pkg::ADDR_SUP1)     ||
                     (rd_addr_i == csr_map_pkg::ADDR_EPC)      ||
                     (rd_addr_i == csr_map_pkg::ADDR_BADVADDR) ||
                     (rd_addr_i == csr_map_pkg::ADDR_COUNT)    ||
                     (rd_addr_i == csr_map_pkg::ADDR_EVEC)     ||
                     (rd_addr_i == csr_map_pkg::ADDR_CAUSE)    ||
                     (rd_addr_i == csr_map_pkg::ADDR_STATUS);

  // flush without a new read drops the checkpoint
  flush_clears_vio: assert property (@(posedge clk) disable iff (reset)
    flush_i && !rd_en_i |=> !atomic_rd_vio_o)
    else
    begin
      fail_count++;
      $error("atomicity flag still high after flush");
    end

  unmapped_reads_zero: assert property (@(posedge clk) disable iff (reset)
    !rd_mapped |-> rd_data_o == '0)
    else
    begin
      fail_count++;
      $error("unmapped read returned nonzero data");
    end

  // exception loads epc unless a committed write lands on it
  exception_loads_epc: assert property (@(posedge clk) disable iff (reset)
    exception_i && !wr_strobe[csr_map_pkg::IDX_EPC]
    |=> csr_epc_o == `CSR_WIDTH'($past(exception_pc_i)))
    else
    begin
      fail_count++;
      $error("epc does not hold the exception pc");
    end

endmodule

bind csr_file_top csr_file_assertions u_assert (
  .clk             (clk),
  .reset           (reset),
  .flush_i         (flush_i),
  .rd_en_i         (rd_en_i),
  .rd_addr_i       (rd_addr_i),
  .rd_data_o       (rd_data_o),
  .atomic_rd_vio_o (atomic_rd_vio_o),
  .exception_i     (exception_i),
  .exception_pc_i  (exception_pc_i),
  .csr_epc_o       (csr_epc_o),
  .wr_strobe       (wr_strobe)
);

// File: tb/csr_file_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the supervisor CSR file
// inputs change on the rising edge, outputs are checked on the falling
// edge against a cycle model of the eight registers, the pending write
// and the read checkpoint
// stimulus comes from an LCG with a fixed seed
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_cfg.svh"

module csr_file_tb;

  logic                         clk;
  logic                         reset;
  logic                         flush_i;
  logic [`CSR_ADDR_WIDTH-1:0]   wr_addr_i;
  logic [`CSR_WIDTH-1:0]        wr_data_i;
  logic                         wr_en_i;
  logic                         commit_i;
  logic [`CSR_ADDR_WIDTH-1:0]   rd_addr_i;
  logic                         rd_en_i;
  logic [`COMMIT_CNT_WIDTH-1:0] commit_total_i;
  logic                         exception_i;
  logic [`PC_WIDTH-1:0]         exception_pc_i;
  logic [`CAUSE_WIDTH-1:0]      exception_cause_i;
  logic [`VADDR_WIDTH-1:0]      ld_commit_addr_i;
  logic [`VADDR_WIDTH-1:0]      st_commit_addr_i;
  logic                         sret_i;
  logic [`CSR_WIDTH-1:0]        rd_data_o;
  logic                         atomic_rd_vio_o;
  logic [`CSR_WIDTH-1:0]        csr_epc_o;
  logic [`CSR_WIDTH-1:0]        csr_evec_o;

  // model state
  logic [`CSR_WIDTH-1:0]      m_regs [`CSR_COUNT];
  logic [`CSR_ADDR_WIDTH-1:0] m_pend_addr;
  logic [`CSR_WIDTH-1:0]      m_pend_data;
  logic                       m_chk_valid;
  int                         m_chk_idx;
  logic [`CSR_WIDTH-1:0]      m_chk_data;

  logic [31:0] lcg_state = 32'haa25_91fd;
  logic        vio_seen;
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;

  csr_file_top dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // bank slot to CSR address
  function automatic logic [`CSR_ADDR_WIDTH-1:0] addr_of(input int idx);
    case (idx)
      csr_map_pkg::IDX_SUP0:     return csr_map_pkg::ADDR_SUP0;
      csr_map_pkg::IDX_SUP1:     return csr_map_pkg::ADDR_SUP1;
      csr_map_pkg::IDX_EPC:      return csr_map_pkg::ADDR_EPC;
      csr_map_pkg::IDX_BADVADDR: return csr_map_pkg::ADDR_BADVADDR;
      csr_map_pkg::IDX_COUNT:    return csr_map_pkg::ADDR_COUNT;
      csr_map_pkg::IDX_EVEC:     return csr_map_pkg::ADDR_EVEC;
      csr_map_pkg::IDX_CAUSE:    return csr_map_pkg::ADDR_CAUSE;
      default:                   return csr_map_pkg::ADDR_STATUS;
    endcase
  endfunction

  // -1 means unmapped
  function automatic int idx_of(input logic [`CSR_ADDR_WIDTH-1:0] addr);
    for (int i = 0; i < `CSR_COUNT; i++)
    begin
      if (addr_of(i) == addr)
        return i;
    end
    return -1;
  endfunction

  function automatic logic [`CSR_WIDTH-1:0] model_read(input int idx);
    return (idx < 0) ? '0 : m_regs[idx];
  endfunction

  // mostly mapped addresses, a quarter random
  function automatic logic [`CSR_ADDR_WIDTH-1:0] pick_addr();
    logic [31:0] r;
    r = next_rand();
    if (r[3:0] < 4'd12)
      return addr_of(int'(r[6:4]));
    return r[27:16];
  endfunction

  task automatic compare(input string name, input logic [`CSR_WIDTH-1:0] exp_val,
                         input logic [`CSR_WIDTH-1:0] act_val);
    checks++;
    if (act_val !== exp_val)
    begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic model_reset();
    for (int i = 0; i < `CSR_COUNT; i++)
      m_regs[i] = '0;
    m_regs[csr_map_pkg::IDX_STATUS] = 64'h61;
    m_pend_addr = '0;
    m_chk_valid = 1'b0;
    m_chk_idx   = -1;
  endtask

  // next state from the inputs held during this cycle
  task automatic model_step();
    logic [`CSR_WIDTH-1:0] nxt [`CSR_COUNT];
    int                    widx;
    int                    ridx;
    nxt = m_regs;
    nxt[csr_map_pkg::IDX_COUNT] = m_regs[csr_map_pkg::IDX_COUNT] + commit_total_i + exception_i;
    if (exception_i)
    begin
      nxt[csr_map_pkg::IDX_EPC]   = `CSR_WIDTH'(exception_pc_i);
      nxt[csr_map_pkg::IDX_CAUSE] = `CSR_WIDTH'(exception_cause_i);
      if (exception_cause_i == 5'd0 || exception_cause_i == 5'd1)
        nxt[csr_map_pkg::IDX_BADVADDR] = `CSR_WIDTH'(exception_pc_i);
      else if (exception_cause_i == 5'd4 || exception_cause_i == 5'd5)
        nxt[csr_map_pkg::IDX_BADVADDR] = `CSR_WIDTH'(ld_commit_addr_i);
      else if (exception_cause_i == 5'd6 || exception_cause_i == 5'd7)
        nxt[csr_map_pkg::IDX_BADVADDR] = `CSR_WIDTH'(st_commit_addr_i);
    end
    // S from PS, EI from PEI
    if (sret_i)
    begin
      nxt[csr_map_pkg::IDX_STATUS][0] = m_regs[csr_map_pkg::IDX_STATUS][1];
      nxt[csr_map_pkg::IDX_STATUS][2] = m_regs[csr_map_pkg::IDX_STATUS][3];
    end
    // committed write last so it wins
    widx = idx_of(m_pend_addr);
    if (commit_i && widx >= 0)
      nxt[widx] = (widx == csr_map_pkg::IDX_STATUS) ? (m_pend_data & 64'hff) : m_pend_data;
    ridx = idx_of(rd_addr_i);
    if (rd_en_i)
    begin
      m_chk_valid = 1'b1;
      m_chk_idx   = ridx;
      m_chk_data  = model_read(ridx);
    end
    else if (flush_i || commit_i)
      m_chk_valid = 1'b0;
    if (wr_en_i)
    begin
      m_pend_addr = wr_addr_i;
      m_pend_data = wr_data_i;
    end
    m_regs = nxt;
  endtask

  task automatic idle_inputs();
    flush_i           <= 1'b0;
    wr_addr_i         <= '0;
    wr_data_i         <= '0;
    wr_en_i           <= 1'b0;
    commit_i          <= 1'b0;
    rd_addr_i         <= '0;
    rd_en_i           <= 1'b0;
    commit_total_i    <= '0;
    exception_i       <= 1'b0;
    exception_pc_i    <= '0;
    exception_cause_i <= '0;
    ld_commit_addr_i  <= '0;
    st_commit_addr_i  <= '0;
    sret_i            <= 1'b0;
  endtask

  // check mid-cycle, advance the model, return on the next rising edge
  task automatic run_cycle();
    logic exp_vio;
    @(negedge clk);
    exp_vio = m_chk_valid && (model_read(m_chk_idx) != m_chk_data);
    vio_seen = atomic_rd_vio_o;
    compare("rd_data_o", model_read(idx_of(rd_addr_i)), rd_data_o);
    compare("atomic_rd_vio_o", `CSR_WIDTH'(exp_vio), `CSR_WIDTH'(atomic_rd_vio_o));
    compare("csr_epc_o", m_regs[csr_map_pkg::IDX_EPC], csr_epc_o);
    compare("csr_evec_o", m_regs[csr_map_pkg::IDX_EVEC], csr_evec_o);
    model_step();
    @(posedge clk);
  endtask

  // poll the flag with count input held, bounded
  task automatic wait_vio(input logic [`COMMIT_CNT_WIDTH-1:0] total, input int limit);
    int n;
    n = 0;
    vio_seen = 1'b0;
    while (!vio_seen && n < limit)
    begin
      idle_inputs();
      commit_total_i <= total;
      run_cycle();
      n++;
    end
    if (!vio_seen)
    begin
      errors++;
      $display("timeout: atomic_rd_vio_o did not rise within %0d cycles", limit);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d mismatches", name, errors - err_before);
  endtask

  task automatic reset_values_test();
    int e0;
    e0 = errors;
    for (int i = 0; i < `CSR_COUNT; i++)
    begin
      idle_inputs();
      rd_addr_i <= addr_of(i);
      run_cycle();
    end
    idle_inputs();
    rd_addr_i <= 12'h7ff;
    run_cycle();
    end_test("reset_values", e0);
  endtask

  task automatic write_commit_test();
    int                         e0;
    logic [`CSR_ADDR_WIDTH-1:0] a;
    e0 = errors;
    for (int n = 0; n < 24; n++)
    begin
      // every mapped register once, then random addresses
      a = (n < `CSR_COUNT) ? addr_of(n) : pick_addr();
      idle_inputs();
      wr_en_i   <= 1'b1;
      wr_addr_i <= a;
      wr_data_i <= {next_rand(), next_rand()};
      rd_addr_i <= a;
      run_cycle();
      // held only, read must not move
      idle_inputs();
      rd_addr_i <= a;
      run_cycle();
      idle_inputs();
      commit_i  <= 1'b1;
      rd_addr_i <= a;
      run_cycle();
      idle_inputs();
      rd_addr_i <= a;
      run_cycle();
    end
    end_test("write_commit", e0);
  endtask

  task automatic exception_count_test();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    repeat (200)
    begin
      r = next_rand();
      idle_inputs();
      exception_i       <= r[0];
      // half the causes from the badvaddr range
      exception_cause_i <= r[1] ? {2'b00, r[4:2]} : r[6:2];
      exception_pc_i    <= next_rand();
      ld_commit_addr_i  <= next_rand();
      st_commit_addr_i  <= next_rand();
      commit_total_i    <= r[9:7];
      wr_en_i           <= (r[12:10] == 3'd0);
      wr_addr_i         <= r[13] ? csr_map_pkg::ADDR_COUNT : pick_addr();
      wr_data_i         <= {next_rand(), next_rand()};
      commit_i          <= (r[16:14] == 3'd0);
      rd_addr_i         <= pick_addr();
      rd_en_i           <= r[17];
      flush_i           <= r[18] & r[19];
      run_cycle();
    end
    end_test("exception_count", e0);
  endtask

  task automatic sret_test();
    int e0;
    e0 = errors;
    repeat (16)
    begin
      idle_inputs();
      wr_en_i   <= 1'b1;
      wr_addr_i <= csr_map_pkg::ADDR_STATUS;
      wr_data_i <= {next_rand(), next_rand()};
      run_cycle();
      idle_inputs();
      commit_i  <= 1'b1;
      rd_addr_i <= csr_map_pkg::ADDR_STATUS;
      run_cycle();
      idle_inputs();
      sret_i    <= 1'b1;
      rd_addr_i <= csr_map_pkg::ADDR_STATUS;
      run_cycle();
      idle_inputs();
      rd_addr_i <= csr_map_pkg::ADDR_STATUS;
      run_cycle();
    end
    end_test("sret", e0);
  endtask

  task automatic atomicity_test();
    int e0;
    e0 = errors;
    // count checkpoint, frozen count first
    idle_inputs();
    rd_en_i   <= 1'b1;
    rd_addr_i <= csr_map_pkg::ADDR_COUNT;
    run_cycle();
    repeat (3)
    begin
      idle_inputs();
      run_cycle();
    end
    wait_vio(3'd1, 20);
    idle_inputs();
    flush_i <= 1'b1;
    run_cycle();
    idle_inputs();
    run_cycle();
    // epc checkpoint broken by an exception, cleared by commit
    idle_inputs();
    rd_en_i   <= 1'b1;
    rd_addr_i <= csr_map_pkg::ADDR_EPC;
    run_cycle();
    idle_inputs();
    exception_i       <= 1'b1;
    exception_cause_i <= 5'd2;
    exception_pc_i    <= m_regs[csr_map_pkg::IDX_EPC][31:0] ^ 32'h0000_0104;
    run_cycle();
    wait_vio(3'd0, 20);
    idle_inputs();
    commit_i <= 1'b1;
    run_cycle();
    // untouched register keeps the flag low while count runs
    idle_inputs();
    rd_en_i   <= 1'b1;
    rd_addr_i <= csr_map_pkg::ADDR_SUP0;
    run_cycle();
    repeat (8)
    begin
      idle_inputs();
      commit_total_i <= `COMMIT_CNT_WIDTH'(next_rand());
      run_cycle();
    end
    end_test("atomicity", e0);
  endtask

  initial
  begin
    reset <= 1'b1;
    idle_inputs();
    model_reset();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    reset_values_test();
    write_commit_test();
    exception_count_test();
    sret_test();
    atomicity_test();
    errors += dut0.u_assert.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: files.f
+incdir+verilog
verilog/csr_map_pkg.sv
verilog/csr_trap_pkg.sv
verilog/csr_commit_decode.sv
verilog/csr_state_regs.sv
verilog/csr_read_check.sv
verilog/csr_file_top.sv
tb/csr_file_assertions.sv
tb/csr_file_tb.sv

// File: Bender.yml
package:
  name: csr_file

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/csr_map_pkg.sv
      - verilog/csr_trap_pkg.sv
      - verilog/csr_commit_decode.sv
      - verilog/csr_state_regs.sv
      - verilog/csr_read_check.sv
      - verilog/csr_file_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/csr_file_assertions.sv
      - tb/csr_file_tb.sv
